/* design/rp_pkg.sv */
////////////////////////////////////////////////////////////
// rp_pkg
// shared sample types, bus geometry, region map and
// register offsets for the fast analog path
////////////////////////////////////////////////////////////

package rp_pkg;

  // sample path
  localparam int SAMPLE_W  = 14;
  localparam int ADC_PIN_W = 16;                 // pins [1:0] unused

  typedef logic signed [SAMPLE_W-1:0] sample_t;  // two's complement
  typedef logic        [SAMPLE_W-1:0] adc_code_t; // neg-slope converter code

  // control bus
  localparam int BUS_AW     = 32;
  localparam int BUS_DW     = 32;
  localparam int N_REGIONS  = 8;
  localparam int REGION_LSB = 20;                // 1 MB per region
  localparam int REGION_MSB = 22;
  localparam int REGION_HK  = 0;
  localparam int REGION_DSP = 3;

  // housekeeping offsets, compared on addr[19:0]
  localparam logic [REGION_LSB-1:0] HK_ID_OFS    = 20'h00000;
  localparam logic [REGION_LSB-1:0] HK_DLOOP_OFS = 20'h0000C;
  localparam logic [REGION_LSB-1:0] HK_LED_OFS   = 20'h00030;
  localparam logic [BUS_DW-1:0]     HK_ID_VALUE  = 32'h5250_0001;
  localparam int                    LED_W        = 8;

  // routing offsets
  localparam logic [REGION_LSB-1:0] RT_SEL_A_OFS   = 20'h00000;
  localparam logic [REGION_LSB-1:0] RT_SEL_B_OFS   = 20'h00004;
  localparam logic [REGION_LSB-1:0] RT_CONST_A_OFS = 20'h00008;
  localparam logic [REGION_LSB-1:0] RT_CONST_B_OFS = 20'h0000C;

  typedef enum logic [1:0] {
    SRC_IN_A  = 2'd0,
    SRC_IN_B  = 2'd1,
    SRC_CONST = 2'd2                             // 2'd3 never stored
  } route_sel_t;

  // sign kept, magnitude bits flipped; same rule both ways
  function automatic sample_t code_to_sample(adc_code_t code);
    return {code[SAMPLE_W-1], ~code[SAMPLE_W-2:0]};
  endfunction

  function automatic adc_code_t sample_to_code(sample_t smp);
    return {smp[SAMPLE_W-1], ~smp[SAMPLE_W-2:0]};
  endfunction

endpackage

/* design/adc_frontend.sv */
////////////////////////////////////////////////////////////
// adc_frontend
// captures both ADC pin buses, converts the neg-slope code
// to two's complement and applies the digital loopback
////////////////////////////////////////////////////////////

module adc_frontend
  import rp_pkg::*;
(
  input  logic                 adc_clk,
  input  logic                 arst_n_i,
  input  logic [ADC_PIN_W-1:0] adc_dat_a_i,    // ADC ch A pins
  input  logic [ADC_PIN_W-1:0] adc_dat_b_i,    // ADC ch B pins
  input  logic                 digital_loop_i, // 1 = take loop samples
  input  sample_t              loop_a_i,       // DAC-side samples
  input  sample_t              loop_b_i,
  output sample_t              adc_a_o,
  output sample_t              adc_b_o
);

  adc_code_t code_a_q;
  adc_code_t code_b_q;

  // input registers, top 14 bits only
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      code_a_q <= '0;
      code_b_q <= '0;
    end
    else
    begin
      code_a_q <= adc_dat_a_i[ADC_PIN_W-1:ADC_PIN_W-SAMPLE_W];
      code_b_q <= adc_dat_b_i[ADC_PIN_W-1:ADC_PIN_W-SAMPLE_W];
    end
  end

  // loopback mux sits after the register
  assign adc_a_o = digital_loop_i ? loop_a_i : code_to_sample(code_a_q);
  assign adc_b_o = digital_loop_i ? loop_b_i : code_to_sample(code_b_q);

  // loop samples come back from the router, so this covers both paths
  a_no_x_samples: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    !$isunknown({adc_a_o, adc_b_o}))
    else $error("adc_frontend: X on sample outputs");

endmodule

/* design/sys_bus_decoder.sv */
////////////////////////////////////////////////////////////
// sys_bus_decoder
// splits the bus into 8 regions of 1 MB, routes the strobes
// and merges read data and ack back to the master
////////////////////////////////////////////////////////////

module sys_bus_decoder
  import rp_pkg::*;
(
  input  logic              adc_clk,
  input  logic              arst_n_i,
  input  logic [BUS_AW-1:0] sys_addr_i,
  input  logic              sys_wen_i,
  input  logic              sys_ren_i,
  input  logic [BUS_DW-1:0] hk_rdata_i,   // region 0
  input  logic              hk_ack_i,
  input  logic [BUS_DW-1:0] rt_rdata_i,   // region 3
  input  logic              rt_ack_i,
  output logic [BUS_DW-1:0] sys_rdata_o,
  output logic              sys_ack_o,
  output logic              sys_err_o,
  output logic              hk_wen_o,
  output logic              hk_ren_o,
  output logic              rt_wen_o,
  output logic              rt_ren_o
);

  logic [REGION_MSB-REGION_LSB:0] region;
  logic [N_REGIONS-1:0]           region_cs;  // one-hot
  logic [BUS_DW-1:0]              rdata_arr [N_REGIONS];
  logic [N_REGIONS-1:0]           ack_arr;
  logic                           strobe;

  assign region    = sys_addr_i[REGION_MSB:REGION_LSB];
  assign region_cs = N_REGIONS'(1) << region;
  assign strobe    = sys_wen_i | sys_ren_i;

  // strobes go only to the addressed region
  assign hk_wen_o = sys_wen_i & region_cs[REGION_HK];
  assign hk_ren_o = sys_ren_i & region_cs[REGION_HK];
  assign rt_wen_o = sys_wen_i & region_cs[REGION_DSP];
  assign rt_ren_o = sys_ren_i & region_cs[REGION_DSP];

  ////////////////////////////////////////////////////////////
  // per-region return path
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int i = 0; i < N_REGIONS; i++)
    begin
      rdata_arr[i] = '0;       // empty region reads zero
      ack_arr[i]   = strobe;   // and answers right away
    end
    rdata_arr[REGION_HK]  = hk_rdata_i;
    ack_arr[REGION_HK]    = hk_ack_i;
    rdata_arr[REGION_DSP] = rt_rdata_i;
    ack_arr[REGION_DSP]   = rt_ack_i;
  end

  assign sys_rdata_o = rdata_arr[region];
  assign sys_ack_o   = |(region_cs & ack_arr);
  assign sys_err_o   = 1'b0;   // no error source

  a_wen_ren_excl: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    !(sys_wen_i && sys_ren_i))
    else $error("sys_bus_decoder: wen and ren high together");

  // registered slaves must answer exactly one cycle later
  a_reg_ack: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    (hk_wen_o || hk_ren_o || rt_wen_o || rt_ren_o) |=> sys_ack_o)
    else $error("sys_bus_decoder: no ack after register access");

endmodule

/* design/housekeeping_regs.sv */
////////////////////////////////////////////////////////////
// housekeeping_regs
// region 0 registers: ID, digital loop flag and LEDs
////////////////////////////////////////////////////////////

module housekeeping_regs
  import rp_pkg::*;
(
  input  logic              adc_clk,
  input  logic              arst_n_i,
  input  logic [BUS_AW-1:0] sys_addr_i,
  input  logic [BUS_DW-1:0] sys_wdata_i,
  input  logic              wen_i,
  input  logic              ren_i,
  output logic [BUS_DW-1:0] rdata_o,
  output logic              ack_o,
  output logic              digital_loop_o,
  output logic [LED_W-1:0]  led_o
);

  logic [REGION_LSB-1:0] ofs;
  logic                  dloop_q;
  logic [LED_W-1:0]      led_q;

  assign ofs = sys_addr_i[REGION_LSB-1:0];  // offset inside region

  // control registers and ack
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dloop_q <= 1'b0;
      led_q   <= '0;
      ack_o   <= 1'b0;
    end
    else
    begin
      ack_o <= wen_i | ren_i;  // one cycle after the pulse
      if (wen_i)
      begin
        if (ofs == HK_DLOOP_OFS) dloop_q <= sys_wdata_i[0];
        if (ofs == HK_LED_OFS)   led_q   <= sys_wdata_i[LED_W-1:0];
      end
    end
  end

  // read data, only looked at together with ack
  always_ff @(posedge adc_clk)
  begin
    if (ren_i)
    begin
      case (ofs)
        HK_ID_OFS:    rdata_o <= HK_ID_VALUE;
        HK_DLOOP_OFS: rdata_o <= BUS_DW'(dloop_q);
        HK_LED_OFS:   rdata_o <= BUS_DW'(led_q);
        default:      rdata_o <= '0;      // unknown offset
      endcase
    end
  end

  assign digital_loop_o = dloop_q;
  assign led_o          = led_q;

endmodule

/* design/dsp_router.sv */
////////////////////////////////////////////////////////////
// dsp_router
// picks, per DAC channel, ADC A, ADC B or a constant and
// registers the result; selects and constants sit in
// region 3
////////////////////////////////////////////////////////////

module dsp_router
  import rp_pkg::*;
(
  input  logic              adc_clk,
  input  logic              arst_n_i,
  input  logic [BUS_AW-1:0] sys_addr_i,
  input  logic [BUS_DW-1:0] sys_wdata_i,
  input  logic              wen_i,
  input  logic              ren_i,
  input  sample_t           in_a_i,
  input  sample_t           in_b_i,
  output logic [BUS_DW-1:0] rdata_o,
  output logic              ack_o,
  output sample_t           out_a_o,
  output sample_t           out_b_o
);

  logic [REGION_LSB-1:0] ofs;
  route_sel_t            sel_a_q;
  route_sel_t            sel_b_q;
  sample_t               const_a_q;
  sample_t               const_b_q;
  logic                  sel_ok;    // write value is a legal source

  function automatic sample_t route(route_sel_t sel, sample_t a, sample_t b, sample_t c);
    case (sel)
      SRC_IN_A: return a;
      SRC_IN_B: return b;
      default:  return c;
    endcase
  endfunction

  assign ofs    = sys_addr_i[REGION_LSB-1:0];
  assign sel_ok = (sys_wdata_i[1:0] != 2'd3);

  ////////////////////////////////////////////////////////////
  // bus registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      sel_a_q   <= SRC_IN_A;
      sel_b_q   <= SRC_IN_B;
      const_a_q <= '0;
      const_b_q <= '0;
      ack_o     <= 1'b0;
    end
    else
    begin
      ack_o <= wen_i | ren_i;
      if (wen_i)
      begin
        // fourth select code is dropped, old source stays
        if (ofs == RT_SEL_A_OFS && sel_ok) sel_a_q <= route_sel_t'(sys_wdata_i[1:0]);
        if (ofs == RT_SEL_B_OFS && sel_ok) sel_b_q <= route_sel_t'(sys_wdata_i[1:0]);
        if (ofs == RT_CONST_A_OFS) const_a_q <= sys_wdata_i[SAMPLE_W-1:0];
        if (ofs == RT_CONST_B_OFS) const_b_q <= sys_wdata_i[SAMPLE_W-1:0];
      end
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (ren_i)
    begin
      case (ofs)
        RT_SEL_A_OFS:   rdata_o <= BUS_DW'(sel_a_q);
        RT_SEL_B_OFS:   rdata_o <= BUS_DW'(sel_b_q);
        RT_CONST_A_OFS: rdata_o <= BUS_DW'(const_a_q);  // sign extended
        RT_CONST_B_OFS: rdata_o <= BUS_DW'(const_b_q);
        default:        rdata_o <= '0;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // sample path, one register stage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      out_a_o <= '0;
      out_b_o <= '0;
    end
    else
    begin
      out_a_o <= route(sel_a_q, in_a_i, in_b_i, const_a_q);
      out_b_o <= route(sel_b_q, in_a_i, in_b_i, const_b_q);
    end
  end

  a_sel_legal: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    (sel_a_q != 2'd3) && (sel_b_q != 2'd3))
    else $error("dsp_router: select register holds unused code");

endmodule

/* design/dac_backend.sv */
////////////////////////////////////////////////////////////
// dac_backend
// converts both channels to neg-slope code and interleaves
// them on one DAC bus, one channel per clock
////////////////////////////////////////////////////////////

module dac_backend
  import rp_pkg::*;
(
  input  logic      adc_clk,
  input  logic      arst_n_i,
  input  sample_t   dac_a_i,
  input  sample_t   dac_b_i,
  output adc_code_t dac_dat_o,   // shared DAC data bus
  output logic      dac_sel_o,   // 1 = ch B on the bus
  output logic      dac_wrt_o    // write strobe
);

  adc_code_t dat_a_q;
  adc_code_t dat_b_q;
  logic      sel_q;

  // output registers + channel toggle
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dat_a_q <= '0;
      dat_b_q <= '0;
      sel_q   <= 1'b0;
    end
    else
    begin
      dat_a_q <= sample_to_code(dac_a_i);
      dat_b_q <= sample_to_code(dac_b_i);
      sel_q   <= ~sel_q;  // flips every cycle
    end
  end

  assign dac_sel_o = sel_q;
  assign dac_wrt_o = ~sel_q;
  assign dac_dat_o = sel_q ? dat_b_q : dat_a_q;  // B while sel high

endmodule

/* design/rp_top.sv */
////////////////////////////////////////////////////////////
// rp_top
// fast analog path: ADC capture, routing, DAC interleave,
// plus the control bus with housekeeping and routing regs
////////////////////////////////////////////////////////////

module rp_top
  import rp_pkg::*;
(
  input  logic                 adc_clk,
  input  logic                 arst_n_i,
  input  logic [ADC_PIN_W-1:0] adc_dat_a_i,
  input  logic [ADC_PIN_W-1:0] adc_dat_b_i,
  input  logic [BUS_AW-1:0]    sys_addr_i,
  input  logic [BUS_DW-1:0]    sys_wdata_i,
  input  logic                 sys_wen_i,
  input  logic                 sys_ren_i,
  output logic [BUS_DW-1:0]    sys_rdata_o,
  output logic                 sys_ack_o,
  output logic                 sys_err_o,
  output adc_code_t            dac_dat_o,
  output logic                 dac_sel_o,
  output logic                 dac_wrt_o,
  output logic                 adc_cdcs_o,  // duty cycle stabilizer
  output logic [LED_W-1:0]     led_o
);

  sample_t           adc_a, adc_b;        // converted ADC samples
  sample_t           dsp_a, dsp_b;        // routed samples to DAC
  logic              digital_loop;
  logic              hk_wen, hk_ren, hk_ack;
  logic              rt_wen, rt_ren, rt_ack;
  logic [BUS_DW-1:0] hk_rdata, rt_rdata;

  assign adc_cdcs_o = 1'b1;  // stabilizer always on

  ////////////////////////////////////////////////////////////
  // control bus
  ////////////////////////////////////////////////////////////

  sys_bus_decoder i_bus (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .hk_rdata_i  (hk_rdata),
    .hk_ack_i    (hk_ack),
    .rt_rdata_i  (rt_rdata),
    .rt_ack_i    (rt_ack),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .hk_wen_o    (hk_wen),
    .hk_ren_o    (hk_ren),
    .rt_wen_o    (rt_wen),
    .rt_ren_o    (rt_ren)
  );

  housekeeping_regs i_hk (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .sys_addr_i     (sys_addr_i),
    .sys_wdata_i    (sys_wdata_i),
    .wen_i          (hk_wen),
    .ren_i          (hk_ren),
    .rdata_o        (hk_rdata),
    .ack_o          (hk_ack),
    .digital_loop_o (digital_loop),
    .led_o          (led_o)
  );

  ////////////////////////////////////////////////////////////
  // sample path, pins to DAC in 3 cycles
  ////////////////////////////////////////////////////////////

  adc_frontend i_adc (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .loop_a_i       (dsp_a),   // loopback from router
    .loop_b_i       (dsp_b),
    .adc_a_o        (adc_a),
    .adc_b_o        (adc_b)
  );

  dsp_router i_dsp (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .wen_i       (rt_wen),
    .ren_i       (rt_ren),
    .in_a_i      (adc_a),
    .in_b_i      (adc_b),
    .rdata_o     (rt_rdata),
    .ack_o       (rt_ack),
    .out_a_o     (dsp_a),
    .out_b_o     (dsp_b)
  );

  dac_backend i_dac (
    .adc_clk   (adc_clk),
    .arst_n_i  (arst_n_i),
    .dac_a_i   (dsp_a),
    .dac_b_i   (dsp_b),
    .dac_dat_o (dac_dat_o),
    .dac_sel_o (dac_sel_o),
    .dac_wrt_o (dac_wrt_o)
  );

endmodule

/* sim/tb_rp_top.sv */
////////////////////////////////////////////////////////////
// tb_rp_top
// testbench for the fast analog path: drives ADC codes and
// bus accesses, checks DAC data and bus timing by assertions
////////////////////////////////////////////////////////////

module tb_rp_top
  import rp_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 100;
  localparam int RESET_CYC  = 16;
  localparam int HOLD_CYC   = 6;     // cycles per ADC code
  localparam int N_HOLDS    = 8;     // holds per sample phase
  localparam int N_PHASES   = 4;     // phases with sample checks
  localparam int N_ACCESSES = 19;
  localparam int ACCESS_CYC = 3;     // worst case, register regions
  localparam int TEST_CYCLES = RESET_CYC + N_PHASES * (N_HOLDS * HOLD_CYC + 2)
                             + N_ACCESSES * ACCESS_CYC + 10;
  localparam int MODE_PASS  = 0;
  localparam int MODE_ROUTE = 1;     // A <- pins B, B <- constant
  localparam int MODE_LOOP  = 2;     // both slots carry the constant
  localparam logic [SAMPLE_W-1:0] MAG_MASK = {1'b0, {(SAMPLE_W-1){1'b1}}};

  logic                 adc_clk;
  logic                 arst_n_i;
  logic [ADC_PIN_W-1:0] adc_dat_a_i, adc_dat_b_i;
  logic [BUS_AW-1:0]    sys_addr_i;
  logic [BUS_DW-1:0]    sys_wdata_i, sys_rdata_o;
  logic                 sys_wen_i, sys_ren_i, sys_ack_o, sys_err_o;
  adc_code_t            dac_dat_o;
  logic                 dac_sel_o, dac_wrt_o, adc_cdcs_o;
  logic [LED_W-1:0]     led_o;

  adc_code_t            exp_a, exp_b;   // model of the two DAC slots
  logic                 check_en;       // slot check armed
  logic [SAMPLE_W-1:0]  cst;            // constant on output B
  logic [31:0]          rng_state = 32'h64ac96c4;
  logic [2:0]           bus_region;
  logic                 hk_pulse, free_read;
  string                test_name;
  int                   value_errs = 0;
  int                   proto_errs = 0;

  rp_top i_dut (.*);

  initial
  begin
    adc_clk = 1'b0;
    forever #(CLK_PERIOD / 2) adc_clk = ~adc_clk;
  end

  // xorshift32, one step per call
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic logic [BUS_AW-1:0] reg_addr(input int region,
                                                 input logic [REGION_LSB-1:0] ofs);
    return (BUS_AW'(region) << REGION_LSB) | BUS_AW'(ofs);
  endfunction

  ////////////////////////////////////////////////////////////
  // bus master, one access at a time
  ////////////////////////////////////////////////////////////

  task automatic bus_access(input logic wr, input logic [BUS_AW-1:0] addr,
                            input logic [BUS_DW-1:0] wdata,
                            output logic [BUS_DW-1:0] rdata);
    @(posedge adc_clk);
    sys_addr_i  <= addr;
    sys_wdata_i <= wdata;
    sys_wen_i   <= wr;
    sys_ren_i   <= !wr;
    @(negedge adc_clk);
    while (!sys_ack_o)
    begin
      @(posedge adc_clk);
      sys_wen_i <= 1'b0;                // single-cycle pulse
      sys_ren_i <= 1'b0;
      @(negedge adc_clk);
    end
    rdata = sys_rdata_o;                // valid with ack
    @(posedge adc_clk);
    sys_wen_i <= 1'b0;
    sys_ren_i <= 1'b0;
  endtask

  task automatic write_reg(input logic [BUS_AW-1:0] addr, input logic [BUS_DW-1:0] data);
    logic [BUS_DW-1:0] unused;
    bus_access(1'b1, addr, data, unused);
  endtask

  task automatic read_reg(input logic [BUS_AW-1:0] addr, output logic [BUS_DW-1:0] data);
    bus_access(1'b0, addr, '0, data);
  endtask

  task automatic check_value(input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      value_errs++;
      $display("ERROR %s: expected %h, actual %h", test_name, expected, actual);
    end
  endtask

  // one ADC code pair held for HOLD_CYC cycles, slot check from cycle 4
  task automatic hold_sample(input int mode);
    logic [31:0] ra, rb;
    ra = next_rand();
    rb = next_rand();
    @(posedge adc_clk);
    adc_dat_a_i <= ra[ADC_PIN_W-1:0];
    adc_dat_b_i <= rb[ADC_PIN_W-1:0];
    check_en    <= 1'b0;
    case (mode)
      MODE_PASS:
      begin
        exp_a <= ra[ADC_PIN_W-1:2];
        exp_b <= rb[ADC_PIN_W-1:2];
      end
      MODE_ROUTE:
      begin
        exp_a <= rb[ADC_PIN_W-1:2];       // pins B in the A slot
        exp_b <= cst ^ MAG_MASK;
      end
      default:
      begin
        exp_a <= cst ^ MAG_MASK;          // pins ignored
        exp_b <= cst ^ MAG_MASK;
      end
    endcase
    repeat (3) @(posedge adc_clk);      // 3-stage pipeline
    check_en <= 1'b1;
    repeat (HOLD_CYC - 4) @(posedge adc_clk);
  endtask

  task automatic stop_checks();
    @(posedge adc_clk);
    check_en <= 1'b0;
    @(posedge adc_clk);
  endtask

  ////////////////////////////////////////////////////////////
  // checkers
  ////////////////////////////////////////////////////////////

  assign bus_region = sys_addr_i[REGION_MSB:REGION_LSB];
  assign hk_pulse   = (sys_wen_i | sys_ren_i) & (bus_region == REGION_HK);
  assign free_read  = sys_ren_i & (bus_region != REGION_HK) & (bus_region != REGION_DSP);

  a_dac_slot: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    check_en |-> dac_dat_o == (dac_sel_o ? exp_b : exp_a))
  else
  begin
    value_errs++;
    $display("ERROR %s: expected %h, actual %h", test_name,
             $sampled(dac_sel_o) ? $sampled(exp_b) : $sampled(exp_a), $sampled(dac_dat_o));
  end

  a_sel_toggle: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    $past(arst_n_i) |-> dac_sel_o != $past(dac_sel_o))
  else
  begin
    proto_errs++;
    $display("%s: dac_sel_o kept its level for two cycles", test_name);
  end

  a_wrt_inv: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    dac_wrt_o == !dac_sel_o)
  else
  begin
    value_errs++;
    $display("ERROR %s: expected %b, actual %b", test_name,
             !$sampled(dac_sel_o), $sampled(dac_wrt_o));
  end

  // region 0 answers exactly one cycle after the pulse
  a_hk_ack: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    hk_pulse |-> !sys_ack_o ##1 sys_ack_o)
  else
  begin
    proto_errs++;
    $display("%s: region 0 ack did not come exactly one cycle after the pulse", test_name);
  end

  a_no_err: assert property (@(posedge adc_clk) disable iff (!arst_n_i) !sys_err_o)
  else
  begin
    proto_errs++;
    $display("%s: sys_err_o went high", test_name);
  end

  // duty cycle stabilizer pin stays on
  a_cdcs_high: assert property (@(posedge adc_clk) disable iff (!arst_n_i) adc_cdcs_o)
  else
  begin
    value_errs++;
    $display("ERROR %s: expected %b, actual %b", test_name, 1'b1, $sampled(adc_cdcs_o));
  end

  a_free_ack: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    free_read |-> sys_ack_o)
  else
  begin
    proto_errs++;
    $display("%s: unused region gave no ack in the read cycle", test_name);
  end

  a_free_zero: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    free_read |-> sys_rdata_o == '0)
  else
  begin
    value_errs++;
    $display("ERROR %s: expected %h, actual %h", test_name, 32'h0, $sampled(sys_rdata_o));
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial
  begin
    logic [BUS_DW-1:0]     rd, rnd;
    logic [BUS_DW-1:0]     rt_wdata [4];
    logic [REGION_LSB-1:0] rt_ofs [4];
    logic [LED_W-1:0]      led_val;
    test_name   = "reset";
    arst_n_i    = 1'b0;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    exp_a       = '0;
    exp_b       = '0;
    check_en    = 1'b0;
    cst         = '0;
    repeat (RESET_CYC) @(posedge adc_clk);
    arst_n_i <= 1'b1;

    test_name = "pass_through";
    repeat (N_HOLDS) hold_sample(MODE_PASS);
    stop_checks();

    test_name = "housekeeping";
    read_reg(reg_addr(REGION_HK, HK_ID_OFS), rd);
    check_value(HK_ID_VALUE, rd);
    rnd     = next_rand();
    led_val = rnd[LED_W-1:0];
    write_reg(reg_addr(REGION_HK, HK_LED_OFS), 32'(led_val));
    @(negedge adc_clk);
    check_value(32'(led_val), 32'(led_o));
    read_reg(reg_addr(REGION_HK, HK_LED_OFS), rd);
    check_value(32'(led_val), rd);

    test_name = "routing";
    rnd = next_rand();
    cst = rnd[SAMPLE_W-1:0];
    rnd = next_rand();                  // constant A, unused by the outputs
    rt_ofs   = '{RT_SEL_A_OFS, RT_SEL_B_OFS, RT_CONST_A_OFS, RT_CONST_B_OFS};
    rt_wdata = '{32'(SRC_IN_B), 32'(SRC_CONST),
                 {{(BUS_DW-SAMPLE_W){rnd[SAMPLE_W-1]}}, rnd[SAMPLE_W-1:0]},
                 {{(BUS_DW-SAMPLE_W){cst[SAMPLE_W-1]}}, cst}};
    for (int i = 0; i < 4; i++)
      write_reg(reg_addr(REGION_DSP, rt_ofs[i]), rt_wdata[i]);
    for (int i = 0; i < 4; i++)
    begin
      read_reg(reg_addr(REGION_DSP, rt_ofs[i]), rd);
      check_value(rt_wdata[i], rd);
    end
    repeat (N_HOLDS) hold_sample(MODE_ROUTE);
    stop_checks();

    test_name = "unused_regions";
    for (int r = 0; r < N_REGIONS; r++)
    begin
      if (r != REGION_HK && r != REGION_DSP)
      begin
        rnd = next_rand();
        read_reg(reg_addr(r, {rnd[REGION_LSB-1:2], 2'b00}), rd);
      end
    end

    test_name = "digital_loop";
    write_reg(reg_addr(REGION_HK, HK_DLOOP_OFS), 32'd1);
    repeat (N_HOLDS) hold_sample(MODE_LOOP);
    stop_checks();

    test_name = "loop_cleared";
    write_reg(reg_addr(REGION_HK, HK_DLOOP_OFS), 32'd0);
    repeat (N_HOLDS) hold_sample(MODE_ROUTE);
    stop_checks();

    $display("checks done: %0d value errors, %0d protocol errors", value_errs, proto_errs);
    if (value_errs + proto_errs == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  // watchdog, test length plus half again
  initial
  begin
    #(TEST_CYCLES * CLK_PERIOD * 3 / 2);
    $display("watchdog: run did not finish within %0d cycles", TEST_CYCLES * 3 / 2);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

/* tb.f */
design/rp_pkg.sv
design/adc_frontend.sv
design/sys_bus_decoder.sv
design/housekeeping_regs.sv
design/dsp_router.sv
design/dac_backend.sv
design/rp_top.sv
sim/tb_rp_top.sv

/* Bender.yml */
package:
  name: rp_fast_path

sources:
  - design/rp_pkg.sv
  - design/adc_frontend.sv
  - design/sys_bus_decoder.sv
  - design/housekeeping_regs.sv
  - design/dsp_router.sv
  - design/dac_backend.sv
  - design/rp_top.sv
  - target: test
    files:
      - sim/tb_rp_top.sv
